//--- design/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// instruction word and field widths
`define INSTR_W     16
`define REG_SEL_W   4
`define ALU_MODE_W  4

// lower byte of the stack pointer pair
`define SP_LOW_REG  4'd14

// ALU pass-through modes
`define ALU_PASS_A  4'd13
`define ALU_PASS_B  4'd0

`endif

//--- design/ctrlPkg.sv
`default_nettype none

`include "ctrl_macros.svh"

package ctrlPkg;

    // op 7 with the marker set falls back to the register form
    typedef struct packed {
        logic [`REG_SEL_W-1:0]           regSel;    // destination register
        logic [`INSTR_W-`REG_SEL_W-5:0]  imm;       // 8-bit immediate / port
        logic [2:0]                      aluOp;
        logic                            immMarker;
    } immForm_t;

    typedef struct packed {
        logic [`REG_SEL_W-1:0] dstCond;  // top three bits are the condition code
        logic [`REG_SEL_W-1:0] src;
        logic [4:0]            opcode;
        logic [2:0]            instrType;
    } regForm_t;

    typedef union packed {
        immForm_t immView;
        regForm_t regView;
    } instrWord_u;

    typedef enum logic [3:0] {
        CLS_ALU_IMM, CLS_ALU_REG, CLS_IN, CLS_OUT, CLS_PAIR,
        CLS_JMP, CLS_CALL, CLS_RET, CLS_HLT, CLS_NOP
    } instrClass_e;

    typedef enum logic [1:0] {STEP_FIRST, STEP_SECOND, STEP_THIRD} ctrlStep_e;

    typedef enum logic [1:0] {PAIR_NONE, PAIR_INC, PAIR_DEC} pairAdj_e;

    // datapath mux encodings
    typedef enum logic [1:0] {REG_SRC_ALU = 2'b00, REG_SRC_IO = 2'b10} regSrc_e;
    typedef enum logic [1:0] {ALU_B_REG = 2'b00, ALU_B_IMM = 2'b10} aluSrcB_e;
    typedef enum logic [2:0] {
        MEM_DATA_PC_HI = 3'b000, MEM_DATA_PC_LO = 3'b001, MEM_DATA_ALU = 3'b010
    } memData_e;
    typedef enum logic [1:0] {
        MEM_ADDR_PAIR = 2'b00, MEM_ADDR_PORT = 2'b01, MEM_ADDR_SP_INC = 2'b10
    } memAddr_e;
    typedef enum logic [2:0] {
        FETCH_PC_INC = 3'b000, FETCH_PC = 3'b001, FETCH_INSTR = 3'b011, FETCH_RET = 3'b101
    } fetchAddr_e;

    typedef struct packed {
        instrClass_e cls;
        instrWord_u  instr;
        pairAdj_e    pairAdj;
        logic        condMet;
    } decoded_t;

    typedef struct packed {
        regSrc_e               writeSrc;
        logic [`REG_SEL_W-1:0] bSel;
        logic                  writeEn;
        logic                  incPair;
        logic                  decPair;
    } regFileCtrl_t;

    typedef struct packed {
        aluSrcB_e               bSrc;
        logic [`ALU_MODE_W-1:0] mode;
        logic                   flagEn;
    } aluCtrl_t;

    typedef struct packed {
        memData_e dataSel;
        memAddr_e addrSel;
        logic     writeEn;
        logic     readEn;
    } memCtrl_t;

    typedef struct packed {
        fetchAddr_e addrSel;
        logic       readEn;
        logic       pcWriteEn;
    } fetchCtrl_t;

endpackage

`default_nettype wire

//--- design/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode import ctrlPkg::*; (
    input  instrWord_u iMemOut,
    input  logic       carryFlag,
    input  logic       zeroFlag,
    input  logic       negativeFlag,
    output decoded_t   decoded
);

    localparam logic [4:0] OP_ALU_LAST  = 5'd12;
    localparam logic [4:0] OP_PAIR_LAST = 5'd18;
    localparam logic [4:0] OP_JMP       = 5'd22;
    localparam logic [4:0] OP_CALL      = 5'd23;
    localparam logic [4:0] OP_RET       = 5'd24;
    localparam logic [4:0] OP_HLT       = 5'd29;

    instrClass_e instrClass;
    pairAdj_e    pairAdj;
    logic        condMet;
    logic [2:0]  condCode;
    logic [4:0]  opcode;

    assign condCode = iMemOut.regView.dstCond[3:1];
    assign opcode   = iMemOut.regView.opcode;

    always_comb begin
        case (condCode)
            3'd1:    condMet = carryFlag;
            3'd2:    condMet = !carryFlag;
            3'd3:    condMet = zeroFlag;
            3'd4:    condMet = !zeroFlag;
            3'd5:    condMet = negativeFlag;
            3'd6:    condMet = !negativeFlag;
            default: condMet = 1'b1;           // codes 0 and 7
        endcase
    end

    always_comb begin
        instrClass = CLS_NOP;                  // also covers the dropped opcodes
        pairAdj    = PAIR_NONE;
        if (iMemOut.immView.immMarker && iMemOut.immView.aluOp != 3'b111) begin
            instrClass = CLS_ALU_IMM;
        end else if (iMemOut.regView.instrType == 3'b010) begin
            instrClass = CLS_IN;
        end else if (iMemOut.regView.instrType == 3'b100) begin
            instrClass = CLS_OUT;
        end else if (iMemOut.regView.instrType == 3'b000) begin
            if (opcode != 5'd0 && opcode <= OP_ALU_LAST) begin
                instrClass = CLS_ALU_REG;
            end else if (opcode > OP_ALU_LAST && opcode <= OP_PAIR_LAST) begin
                instrClass = CLS_PAIR;
                case (opcode)
                    5'd14, 5'd17: pairAdj = PAIR_INC;
                    5'd15, 5'd18: pairAdj = PAIR_DEC;
                    default:      pairAdj = PAIR_NONE;
                endcase
            end else begin
                case (opcode)
                    OP_JMP:  instrClass = CLS_JMP;
                    OP_CALL: instrClass = CLS_CALL;
                    OP_RET:  instrClass = CLS_RET;
                    OP_HLT:  instrClass = CLS_HLT;
                    default: instrClass = CLS_NOP;
                endcase
            end
        end
    end

    assign decoded = '{cls: instrClass, instr: iMemOut, pairAdj: pairAdj, condMet: condMet};

endmodule

`default_nettype wire

//--- design/ctrlSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module ctrlSequencer import ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  decoded_t  decoded,
    output ctrlStep_e step
);

    ctrlStep_e nextStep;
    logic      isPairLoad;
    logic      isBranch;
    logic      lastStep;

    // opcode bit 4 splits pair loads from stores
    assign isPairLoad = decoded.cls == CLS_PAIR && decoded.instr.regView.opcode[4];
    assign isBranch   = decoded.cls inside {CLS_JMP, CLS_CALL, CLS_RET};

    always_comb begin
        case (step)
            STEP_FIRST: begin
                lastStep = !(decoded.cls == CLS_IN || isPairLoad
                             || (isBranch && decoded.condMet));
            end
            STEP_SECOND: lastStep = decoded.cls != CLS_RET;  // only RET needs a third
            default:     lastStep = 1'b1;
        endcase
    end

    // HLT counts as done here and simply re-enters FIRST
    always_comb begin
        if (lastStep) begin
            nextStep = STEP_FIRST;
        end else if (step == STEP_FIRST) begin
            nextStep = STEP_SECOND;
        end else begin
            nextStep = STEP_THIRD;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= STEP_FIRST;
        end else begin
            step <= nextStep;
        end
    end

endmodule

`default_nettype wire

//--- design/ctrlWordGen.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_macros.svh"

module ctrlWordGen import ctrlPkg::*; (
    input  decoded_t     decoded,
    input  ctrlStep_e    step,
    output regFileCtrl_t regCtrl,
    output aluCtrl_t     aluCtrl,
    output memCtrl_t     memCtrl,
    output fetchCtrl_t   fetchCtrl
);

    instrWord_u instr;
    logic       taken;
    logic       isLoad;
    logic       finalStep;

    assign instr  = decoded.instr;
    assign taken  = decoded.condMet || step != STEP_FIRST;  // later steps only follow a taken branch
    assign isLoad = instr.regView.opcode[4];

    always_comb begin
        regCtrl = '{writeSrc: REG_SRC_ALU, bSel: instr.regView.dstCond,
                    writeEn: 1'b0, incPair: 1'b0, decPair: 1'b0};
        aluCtrl = '{bSrc: ALU_B_REG, mode: `ALU_PASS_B, flagEn: 1'b0};
        memCtrl = '{dataSel: MEM_DATA_ALU, addrSel: MEM_ADDR_PAIR,
                    writeEn: 1'b0, readEn: 1'b0};
        fetchCtrl.addrSel = FETCH_PC;
        finalStep = 1'b1;
        case (decoded.cls)
            CLS_ALU_IMM: begin
                regCtrl.bSel    = instr.immView.regSel;
                regCtrl.writeEn = 1'b1;
                aluCtrl.bSrc    = ALU_B_IMM;
                aluCtrl.mode    = {1'b0, instr.immView.aluOp};
                aluCtrl.flagEn  = instr.immView.aluOp != 3'b000;  // LDI leaves flags alone
            end
            CLS_ALU_REG: begin
                regCtrl.bSel    = instr.regView.src;
                regCtrl.writeEn = 1'b1;
                aluCtrl.mode    = instr.regView.opcode[3:0];
                aluCtrl.flagEn  = 1'b1;
            end
            CLS_IN: begin
                finalStep        = step == STEP_SECOND;   // wait one cycle for the port data
                regCtrl.writeSrc = REG_SRC_IO;
                regCtrl.writeEn  = finalStep;
                memCtrl.addrSel  = MEM_ADDR_PORT;
                memCtrl.readEn   = 1'b1;
            end
            CLS_OUT: begin
                memCtrl.addrSel = MEM_ADDR_PORT;
                memCtrl.writeEn = 1'b1;
            end
            CLS_PAIR: begin
                finalStep       = !isLoad || step == STEP_SECOND;
                regCtrl.bSel    = {instr.regView.src[3:1], 1'b0};  // pair base register
                regCtrl.writeEn = isLoad && finalStep;
                regCtrl.incPair = finalStep && decoded.pairAdj == PAIR_INC;
                regCtrl.decPair = finalStep && decoded.pairAdj == PAIR_DEC;
                aluCtrl.mode    = `ALU_PASS_A;
                memCtrl.readEn  = isLoad;
                memCtrl.writeEn = !isLoad;
            end
            CLS_JMP: begin
                if (taken) begin
                    finalStep         = step == STEP_SECOND;
                    fetchCtrl.addrSel = finalStep ? FETCH_INSTR : FETCH_PC;
                end else begin
                    fetchCtrl.addrSel = FETCH_PC_INC;     // skip the address word
                end
            end
            CLS_CALL: begin
                regCtrl.bSel = `SP_LOW_REG;
                if (taken) begin
                    finalStep         = step == STEP_SECOND;
                    regCtrl.decPair   = 1'b1;
                    memCtrl.writeEn   = 1'b1;
                    memCtrl.dataSel   = finalStep ? MEM_DATA_PC_HI : MEM_DATA_PC_LO;
                    fetchCtrl.addrSel = finalStep ? FETCH_INSTR : FETCH_PC;
                end else begin
                    fetchCtrl.addrSel = FETCH_PC_INC;
                end
            end
            CLS_RET: begin
                regCtrl.bSel = `SP_LOW_REG;
                if (taken) begin
                    finalStep         = step == STEP_THIRD;
                    regCtrl.incPair   = !finalStep;       // pop two bytes
                    memCtrl.addrSel   = MEM_ADDR_SP_INC;
                    memCtrl.readEn    = 1'b1;
                    fetchCtrl.addrSel = FETCH_RET;
                end
            end
            CLS_HLT: finalStep = 1'b0;                    // never completes
            default: finalStep = 1'b1;
        endcase
        fetchCtrl.readEn    = finalStep;
        fetchCtrl.pcWriteEn = finalStep;
    end

endmodule

`default_nettype wire

//--- design/ctrlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module ctrlUnit import ctrlPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  instrWord_u   iMemOut,
    input  logic         carryFlag,
    input  logic         zeroFlag,
    input  logic         negativeFlag,
    output regFileCtrl_t regCtrl,
    output aluCtrl_t     aluCtrl,
    output memCtrl_t     memCtrl,
    output fetchCtrl_t   fetchCtrl
);

    decoded_t  decoded;
    ctrlStep_e step;

    instrDecode uDecode (
        .iMemOut(iMemOut),
        .carryFlag(carryFlag),
        .zeroFlag(zeroFlag),
        .negativeFlag(negativeFlag),
        .decoded(decoded)
    );

    ctrlSequencer uSequencer (
        .clk(clk),
        .rstN(rstN),
        .decoded(decoded),
        .step(step)
    );

    ctrlWordGen uWordGen (
        .decoded(decoded),
        .step(step),
        .regCtrl(regCtrl),
        .aluCtrl(aluCtrl),
        .memCtrl(memCtrl),
        .fetchCtrl(fetchCtrl)
    );

endmodule

`default_nettype wire

//--- verif/ctrlUnit_sva.sv
`timescale 1ns/10ps
`default_nettype none

module ctrlUnitSva import ctrlPkg::*; (
    input logic         clk,
    input logic         rstN,
    input ctrlStep_e    step,
    input regFileCtrl_t regCtrl,
    input memCtrl_t     memCtrl,
    input fetchCtrl_t   fetchCtrl
);

    // one data memory access per cycle
    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memCtrl.readEn && memCtrl.writeEn))
        else $error("memory read and write enables both high");

    pairExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(regCtrl.incPair && regCtrl.decPair))
        else $error("pair increment and decrement both high");

    // RET keeps the PC until its last pop is done
    retHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
        fetchCtrl.addrSel == FETCH_RET && step != STEP_THIRD |-> !fetchCtrl.pcWriteEn)
        else $error("PC written before the final RET step");

endmodule

bind ctrlUnit ctrlUnitSva uSva (
    .clk(clk),
    .rstN(rstN),
    .step(step),
    .regCtrl(regCtrl),
    .memCtrl(memCtrl),
    .fetchCtrl(fetchCtrl)
);

`default_nettype wire

//--- verif/ctrlUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module ctrlUnitTb import ctrlPkg::*; ();

    localparam int         NUM_TESTS  = 6;
    localparam int         CLK_PERIOD = 100;
    localparam logic [4:0] OPC_JMP    = 5'd22;
    localparam logic [4:0] OPC_CALL   = 5'd23;
    localparam logic [4:0] OPC_RET    = 5'd24;
    localparam logic [4:0] OPC_HLT    = 5'd29;
    localparam logic [3:0] SP_LOW     = 4'd14;

    // which cycle of which instruction the DUT is in
    typedef enum logic [4:0] {
        PH_IDLE, PH_ALU, PH_IN_WAIT, PH_IN_DONE, PH_OUT, PH_STORE, PH_LOAD_WAIT,
        PH_LOAD_DONE, PH_SKIP, PH_JMP_WAIT, PH_JMP_DONE, PH_CALL_LO, PH_CALL_HI,
        PH_RET_POP, PH_RET_DONE, PH_HLT, PH_NOP
    } phase_e;

    typedef struct packed {
        logic [3:0] regSel;   // B register or pair base
        logic [3:0] mode;
        aluSrcB_e   bSrc;
        logic       flagEn;
        logic       incPair;
        logic       decPair;
    } expect_t;

    logic         clk;
    logic         rstN;
    instrWord_u   iMemOut;
    logic         carryFlag;
    logic         zeroFlag;
    logic         negativeFlag;
    regFileCtrl_t regCtrl;
    aluCtrl_t     aluCtrl;
    memCtrl_t     memCtrl;
    fetchCtrl_t   fetchCtrl;
    phase_e       ph;
    expect_t      want;
    int           errCount;
    int           errMark;
    int           testCount;

    ctrlUnit i_dut (
        .clk(clk),
        .rstN(rstN),
        .iMemOut(iMemOut),
        .carryFlag(carryFlag),
        .zeroFlag(zeroFlag),
        .negativeFlag(negativeFlag),
        .regCtrl(regCtrl),
        .aluCtrl(aluCtrl),
        .memCtrl(memCtrl),
        .fetchCtrl(fetchCtrl)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = !clk;

    task automatic reportFail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        errCount++;
    endtask

    aluOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_ALU |-> regCtrl.bSel == want.regSel && aluCtrl.mode == want.mode
            && aluCtrl.bSrc == want.bSrc && aluCtrl.flagEn == want.flagEn
            && regCtrl.writeEn && fetchCtrl.pcWriteEn)
        else reportFail("ALU control does not match the instruction fields");
    inWaitOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_IN_WAIT |-> memCtrl.readEn && !regCtrl.writeEn && !fetchCtrl.pcWriteEn)
        else reportFail("IN first cycle is not a bare port read");
    inDoneOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_IN_DONE |-> regCtrl.writeEn && regCtrl.writeSrc == REG_SRC_IO
            && fetchCtrl.pcWriteEn)
        else reportFail("IN second cycle does not write the register and end");
    outOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_OUT |-> memCtrl.writeEn && memCtrl.addrSel == MEM_ADDR_PORT
            && fetchCtrl.pcWriteEn)
        else reportFail("OUT is not a one-cycle port write");
    pairOk: assert property (@(posedge clk) disable iff (!rstN)
        ph inside {PH_STORE, PH_LOAD_DONE} |-> regCtrl.bSel == want.regSel
            && regCtrl.incPair == want.incPair && regCtrl.decPair == want.decPair
            && regCtrl.writeEn == (ph == PH_LOAD_DONE) && fetchCtrl.pcWriteEn)
        else reportFail("pair access control wrong in its final cycle");
    loadWaitOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_LOAD_WAIT |-> memCtrl.readEn && !regCtrl.writeEn && !fetchCtrl.pcWriteEn)
        else reportFail("pair load ended or wrote too early");
    skipOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_SKIP |-> fetchCtrl.addrSel == FETCH_PC_INC && fetchCtrl.pcWriteEn)
        else reportFail("untaken branch does not skip in one cycle");
    jmpWaitOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_JMP_WAIT |-> fetchCtrl.addrSel == FETCH_PC && !fetchCtrl.pcWriteEn)
        else reportFail("taken JMP first cycle wrong");
    jmpDoneOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_JMP_DONE |-> fetchCtrl.addrSel == FETCH_INSTR && fetchCtrl.pcWriteEn)
        else reportFail("taken JMP does not fetch its target");
    callLoOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_CALL_LO |-> memCtrl.writeEn && memCtrl.dataSel == MEM_DATA_PC_LO
            && regCtrl.decPair && regCtrl.bSel == SP_LOW && !fetchCtrl.pcWriteEn)
        else reportFail("CALL does not push the low byte first");
    callHiOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_CALL_HI |-> memCtrl.writeEn && memCtrl.dataSel == MEM_DATA_PC_HI
            && fetchCtrl.addrSel == FETCH_INSTR && fetchCtrl.pcWriteEn)
        else reportFail("CALL second cycle wrong");
    retPopOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_RET_POP |-> regCtrl.incPair && regCtrl.bSel == SP_LOW
            && memCtrl.addrSel == MEM_ADDR_SP_INC && fetchCtrl.addrSel == FETCH_RET
            && !fetchCtrl.pcWriteEn)
        else reportFail("RET pop cycle wrong");
    retDoneOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_RET_DONE |-> !regCtrl.incPair && fetchCtrl.addrSel == FETCH_RET
            && fetchCtrl.pcWriteEn)
        else reportFail("RET does not end in its third cycle");
    hltOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_HLT |-> !fetchCtrl.pcWriteEn && !fetchCtrl.readEn)
        else reportFail("HLT let the PC or the fetch move");
    nopOk: assert property (@(posedge clk) disable iff (!rstN)
        ph == PH_NOP |-> fetchCtrl.pcWriteEn && fetchCtrl.readEn)
        else reportFail("one-cycle instruction did not complete");

    function automatic instrWord_u immWord(input logic [3:0] r, input logic [7:0] imm,
                                           input logic [2:0] op);
        return {r, imm, op, 1'b1};
    endfunction

    function automatic instrWord_u regWord(input logic [3:0] dc, input logic [3:0] src,
                                           input logic [4:0] opc, input logic [2:0] t);
        return {dc, src, opc, t};
    endfunction

    function automatic logic condHolds(input logic [2:0] code, input logic [2:0] flags);
        logic flag;
        if (code == 3'd0 || code == 3'd7) begin
            return 1'b1;
        end
        flag = code < 3'd3 ? flags[2] : (code < 3'd5 ? flags[1] : flags[0]);
        return code[0] ? flag : !flag;   // odd codes want the flag set
    endfunction

    task automatic applyCycle(input phase_e p, input instrWord_u w, input logic [2:0] flags,
                              input expect_t e);
        @(posedge clk);
        #5;
        iMemOut = w;
        {carryFlag, zeroFlag, negativeFlag} = flags;
        ph = p;
        want = e;
    endtask

    // the idle cycle lets the last check fire before the verdict
    task automatic endTest(input string name);
        applyCycle(PH_IDLE, '0, 3'b000, '0);
        if (errCount == errMark) begin
            $display("test %0d %s: pass", testCount + 1, name);
        end else begin
            $display("test %0d %s: %0d failed checks", testCount + 1, name, errCount - errMark);
        end
        errMark = errCount;
        testCount++;
    endtask

    initial begin
        logic [3:0] r;
        logic [2:0] pair;
        logic [2:0] flags;
        logic [4:0] opc;
        instrWord_u w;
        expect_t    e;
        int         seedVal;
        seedVal = $urandom(63);
        rstN = 1'b0;
        iMemOut = '0;
        {carryFlag, zeroFlag, negativeFlag} = 3'b000;
        ph = PH_IDLE;
        want = '0;
        errCount = 0;
        errMark = 0;
        testCount = 0;
        repeat (4) @(posedge clk);
        #5;
        rstN = 1'b1;

        for (int i = 0; i < 7; i++) begin
            r = 4'($urandom);
            e = '{regSel: r, mode: 4'(i), bSrc: ALU_B_IMM, flagEn: i != 0,
                  incPair: 1'b0, decPair: 1'b0};
            applyCycle(PH_ALU, immWord(r, 8'($urandom), 3'(i)), 3'($urandom), e);
        end
        for (int i = 0; i < 6; i++) begin
            r = 4'($urandom);
            opc = 5'($urandom_range(1, 12));
            e = '{regSel: r, mode: opc[3:0], bSrc: ALU_B_REG, flagEn: 1'b1,
                  incPair: 1'b0, decPair: 1'b0};
            applyCycle(PH_ALU, regWord(4'($urandom), r, opc, 3'b000), 3'($urandom), e);
        end
        endTest("alu forms");

        w = regWord(4'($urandom), 4'($urandom), 5'($urandom), 3'b010);
        applyCycle(PH_IN_WAIT, w, 3'b000, '0);
        applyCycle(PH_IN_DONE, w, 3'b000, '0);
        applyCycle(PH_OUT, regWord(4'($urandom), 4'($urandom), 5'($urandom), 3'b100),
                   3'b000, '0);
        endTest("in and out");

        for (int o = 13; o <= 18; o++) begin
            pair = 3'($urandom);
            e = '{regSel: {pair, 1'b0}, mode: 4'd0, bSrc: ALU_B_REG, flagEn: 1'b0,
                  incPair: o == 14 || o == 17, decPair: o == 15 || o == 18};
            w = regWord(4'($urandom), {pair, 1'($urandom)}, 5'(o), 3'b000);
            if (o < 16) begin
                applyCycle(PH_STORE, w, 3'b000, e);
            end else begin
                applyCycle(PH_LOAD_WAIT, w, 3'b000, e);  // loads are 16 to 18
                applyCycle(PH_LOAD_DONE, w, 3'b000, e);
            end
        end
        endTest("pair load store");

        for (int code = 0; code < 8; code++) begin
            flags = 3'($urandom);
            for (int k = 0; k < 2; k++) begin
                w = regWord({3'(code), 1'($urandom)}, 4'($urandom), OPC_JMP, 3'b000);
                if (condHolds(3'(code), flags)) begin
                    applyCycle(PH_JMP_WAIT, w, flags, '0);
                    applyCycle(PH_JMP_DONE, w, flags, '0);
                end else begin
                    applyCycle(PH_SKIP, w, flags, '0);
                end
                flags = ~flags;             // flips the outcome of codes 1 to 6
            end
        end
        endTest("conditional jmp");

        flags = 3'($urandom);
        w = regWord({3'd0, 1'($urandom)}, 4'($urandom), OPC_CALL, 3'b000);
        applyCycle(PH_CALL_LO, w, flags, '0);
        applyCycle(PH_CALL_HI, w, flags, '0);
        w = regWord({3'd7, 1'($urandom)}, 4'($urandom), OPC_RET, 3'b000);
        applyCycle(PH_RET_POP, w, flags, '0);
        applyCycle(PH_RET_POP, w, flags, '0);
        applyCycle(PH_RET_DONE, w, flags, '0);
        // code 1 with carry clear
        applyCycle(PH_SKIP, regWord(4'd2, 4'($urandom), OPC_CALL, 3'b000), 3'b011, '0);
        applyCycle(PH_NOP, regWord(4'd3, 4'($urandom), OPC_RET, 3'b000), 3'b011, '0);
        endTest("call and ret");

        w = regWord(4'($urandom), 4'($urandom), OPC_HLT, 3'b000);
        repeat (4) applyCycle(PH_HLT, w, 3'($urandom), '0);
        applyCycle(PH_IDLE, '0, 3'b000, '0);
        rstN = 1'b0;
        applyCycle(PH_NOP, '0, 3'b000, '0);
        rstN = 1'b1;
        endTest("hlt and nop");

        $display("tests run: %0d, failed checks: %0d", testCount, errCount);
        if (errCount == 0 && testCount == NUM_TESTS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS * 40 + 4) * CLK_PERIOD);
        $display("watchdog expired: the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ctrlUnit.f
+incdir+design
design/ctrlPkg.sv
design/instrDecode.sv
design/ctrlSequencer.sv
design/ctrlWordGen.sv
design/ctrlUnit.sv
verif/ctrlUnit_sva.sv
verif/ctrlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the ctrlUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module ctrlUnitTb -f ctrlUnit.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

simOut=$(./obj_dir/VctrlUnitTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST OK" <<< "$simOut"; then
    exit 0
fi
exit 1
